//--- source/cache_types_pkg.sv
package cache_types_pkg;

	localparam int addr_w = 16;
	localparam int line_bytes = 16;
	localparam int line_w = line_bytes * 8;
	localparam int num_sets = 8;
	localparam int index_w = $clog2(num_sets);
	localparam int offset_w = $clog2(line_bytes);
	localparam int tag_w = addr_w - index_w - offset_w; // 9 bits.

	typedef logic [tag_w-1:0] tag_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [line_w-1:0] line_t;
	typedef logic [line_bytes-1:0] byte_mask_t;

	typedef struct packed {
		tag_t tag;
		index_t index;
		logic [offset_w-1:0] offset;
	} cache_addr_t;

	typedef struct packed {
		logic valid0_write;
		logic valid1_write;
		logic valid_in;
		logic dirty0_write;
		logic dirty1_write;
		logic dirty_in;
		logic tag0_write;
		logic tag1_write;
		logic data0_write;
		logic data1_write;
		logic lru_write;
		logic lru_in;
		logic pmem_addr_sel; // 1 selects the write-back address.
		logic data_sel; // 1 selects the fill line.
	} array_wr_t;

	typedef struct packed {
		logic hit;
		logic way0_hit;
		logic lru;
		logic victim_dirty;
	} way_status_t;

endpackage

//--- source/cache_array.sv
`timescale 1ns/1ps

module cache_array #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic write,
	input cache_types_pkg::index_t index,
	input payload_t datain,
	output payload_t dataout
);

	import cache_types_pkg::*;

	payload_t entries [num_sets];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_sets; i++) begin
				entries[i] <= '0;
			end
		end else if (write) begin
			entries[index] <= datain;
		end
	end

	// Contents visible to the FSM in the same cycle.
	assign dataout = entries[index];

endmodule

//--- source/l1_cache_datapath.sv
`timescale 1ns/1ps

module l1_cache_datapath (
	input logic clk,
	input logic arst_n,
	input cache_types_pkg::cache_addr_t mem_address,
	input cache_types_pkg::line_t cpu_data,
	input cache_types_pkg::line_t pmem_data,
	input cache_types_pkg::byte_mask_t mem_byte_enable,
	input cache_types_pkg::array_wr_t ctrl,
	output cache_types_pkg::way_status_t status,
	output cache_types_pkg::line_t data_out,
	output cache_types_pkg::line_t pdata_out,
	output logic [15:0] pmem_address
);

	import cache_types_pkg::*;

	logic valid0;
	logic valid1;
	logic dirty0;
	logic dirty1;
	logic lru;
	tag_t tag0;
	tag_t tag1;
	tag_t victim_tag;
	line_t data0;
	line_t data1;
	line_t merged;
	line_t data_in;
	logic way0_hit;
	logic way1_hit;
	logic [addr_w-1:0] line_address;
	logic [addr_w-1:0] wb_address;

	cache_array #(.payload_t(logic)) i_valid0 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.valid0_write),
		.index(mem_address.index),
		.datain(ctrl.valid_in),
		.dataout(valid0)
	);

	cache_array #(.payload_t(logic)) i_valid1 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.valid1_write),
		.index(mem_address.index),
		.datain(ctrl.valid_in),
		.dataout(valid1)
	);

	cache_array #(.payload_t(logic)) i_dirty0 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.dirty0_write),
		.index(mem_address.index),
		.datain(ctrl.dirty_in),
		.dataout(dirty0)
	);

	cache_array #(.payload_t(logic)) i_dirty1 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.dirty1_write),
		.index(mem_address.index),
		.datain(ctrl.dirty_in),
		.dataout(dirty1)
	);

	cache_array #(.payload_t(logic)) i_lru (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.lru_write),
		.index(mem_address.index),
		.datain(ctrl.lru_in),
		.dataout(lru) // Way to replace next.
	);

	cache_array #(.payload_t(tag_t)) i_tag0 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.tag0_write),
		.index(mem_address.index),
		.datain(mem_address.tag),
		.dataout(tag0)
	);

	cache_array #(.payload_t(tag_t)) i_tag1 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.tag1_write),
		.index(mem_address.index),
		.datain(mem_address.tag),
		.dataout(tag1)
	);

	cache_array #(.payload_t(line_t)) i_data0 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.data0_write),
		.index(mem_address.index),
		.datain(data_in),
		.dataout(data0)
	);

	cache_array #(.payload_t(line_t)) i_data1 (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.data1_write),
		.index(mem_address.index),
		.datain(data_in),
		.dataout(data1)
	);

	assign way0_hit = valid0 && (tag0 == mem_address.tag);
	assign way1_hit = valid1 && (tag1 == mem_address.tag);

	assign status.hit = way0_hit | way1_hit;
	assign status.way0_hit = way0_hit;
	assign status.lru = lru;
	assign status.victim_dirty = lru ? dirty1 : dirty0;

	assign data_out = way0_hit ? data0 : data1;

	// CPU bytes over the resident line.
	always_comb begin
		for (int i = 0; i < line_bytes; i++) begin
			merged[8*i +: 8] = mem_byte_enable[i] ? cpu_data[8*i +: 8] : data_out[8*i +: 8];
		end
	end

	assign data_in = ctrl.data_sel ? pmem_data : merged;

	assign pdata_out = lru ? data1 : data0;
	assign victim_tag = lru ? tag1 : tag0;

	assign line_address = {mem_address.tag, mem_address.index, {offset_w{1'b0}}};
	assign wb_address = {victim_tag, mem_address.index, {offset_w{1'b0}}};
	assign pmem_address = ctrl.pmem_addr_sel ? wb_address : line_address;

	// Fill only ever targets the way that missed, so one tag per set.
	a_one_way_hit: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(mem_address) |-> !(way0_hit && way1_hit))
		else $error("both ways hit for address %h", mem_address);

endmodule

//--- source/l1_cache_control.sv
`timescale 1ns/1ps

module l1_cache_control (
	input logic clk,
	input logic arst_n,
	input logic mem_read,
	input logic mem_write,
	input cache_types_pkg::way_status_t status,
	input logic pmem_resp,
	output cache_types_pkg::array_wr_t ctrl,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write
);

	import cache_types_pkg::*;

	typedef enum logic [1:0] {
		COMPARE,
		WRITEBACK,
		FILL
	} state_t;

	state_t state;
	state_t state_next;
	logic request;

	assign request = mem_read | mem_write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= COMPARE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		ctrl = '0;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		unique case (state)
			COMPARE: begin
				if (request && status.hit) begin
					mem_resp = 1'b1;
					ctrl.lru_write = 1'b1;
					ctrl.lru_in = status.way0_hit; // Point at the other way.
					if (mem_write) begin
						ctrl.data_sel = 1'b0;
						ctrl.data0_write = status.way0_hit;
						ctrl.data1_write = !status.way0_hit;
						ctrl.dirty_in = 1'b1;
						ctrl.dirty0_write = status.way0_hit;
						ctrl.dirty1_write = !status.way0_hit;
					end
				end else if (request) begin
					state_next = status.victim_dirty ? WRITEBACK : FILL;
				end
			end

			WRITEBACK: begin
				pmem_write = 1'b1;
				ctrl.pmem_addr_sel = 1'b1; // Victim tag, same index.
				if (pmem_resp) begin
					ctrl.dirty_in = 1'b0;
					ctrl.dirty0_write = !status.lru;
					ctrl.dirty1_write = status.lru;
					state_next = FILL;
				end
			end

			FILL: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctrl.data_sel = 1'b1;
					ctrl.data0_write = !status.lru;
					ctrl.data1_write = status.lru;
					ctrl.tag0_write = !status.lru;
					ctrl.tag1_write = status.lru;
					ctrl.valid_in = 1'b1;
					ctrl.valid0_write = !status.lru;
					ctrl.valid1_write = status.lru;
					ctrl.dirty_in = 1'b0;
					ctrl.dirty0_write = !status.lru;
					ctrl.dirty1_write = status.lru;
					ctrl.lru_write = 1'b1;
					ctrl.lru_in = !status.lru;
					state_next = COMPARE; // Request now hits.
				end
			end

			default: begin
				state_next = COMPARE;
			end
		endcase
	end

	a_cpu_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

	// A hit answers and the request drops before the next compare.
	a_resp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |=> !mem_resp)
		else $error("mem_resp held for more than one cycle");

	a_pmem_resp_solicited: assert property (@(posedge clk) disable iff (!arst_n)
		pmem_resp |-> (pmem_read || pmem_write))
		else $error("pmem_resp without an outstanding memory strobe");

endmodule

//--- source/l1_cache.sv
`timescale 1ns/1ps

module l1_cache (
	input logic clk,
	input logic arst_n,
	input logic mem_read,
	input logic mem_write,
	input cache_types_pkg::cache_addr_t mem_address,
	input cache_types_pkg::line_t mem_wdata,
	input cache_types_pkg::byte_mask_t mem_byte_enable,
	output logic mem_resp,
	output cache_types_pkg::line_t mem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output logic [15:0] pmem_address,
	output cache_types_pkg::line_t pmem_wdata,
	input cache_types_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	import cache_types_pkg::*;

	array_wr_t ctrl;
	way_status_t status;

	l1_cache_control i_control (
		.clk(clk),
		.arst_n(arst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.status(status),
		.pmem_resp(pmem_resp),
		.ctrl(ctrl),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	l1_cache_datapath i_datapath (
		.clk(clk),
		.arst_n(arst_n),
		.mem_address(mem_address),
		.cpu_data(mem_wdata),
		.pmem_data(pmem_rdata),
		.mem_byte_enable(mem_byte_enable),
		.ctrl(ctrl),
		.status(status),
		.data_out(mem_rdata), // Hit line.
		.pdata_out(pmem_wdata), // Victim line.
		.pmem_address(pmem_address)
	);

endmodule

//--- tb/l1_cache_checker.sv
`timescale 1ns/1ps

module l1_cache_checker (
	input logic clk,
	input logic arst_n,
	input logic mem_read,
	input logic mem_write,
	input cache_types_pkg::cache_addr_t mem_address,
	input cache_types_pkg::line_t mem_wdata,
	input cache_types_pkg::byte_mask_t mem_byte_enable,
	input logic mem_resp,
	input cache_types_pkg::line_t mem_rdata,
	input logic pmem_read,
	input logic pmem_write,
	input logic [15:0] pmem_address,
	input cache_types_pkg::line_t pmem_wdata,
	input logic pmem_resp,
	input logic [2:0] test_num,
	input logic test_end,
	input logic run_done,
	output int errors
);

	import cache_types_pkg::*;

	logic [7:0] ref_mem [65536];
	int test_errors;
	int fills;
	int write_backs;
	int tests_run;
	int tests_failed;
	logic resp_seen;
	logic [15:0] line_base;

	function automatic logic [7:0] pattern_byte(input logic [15:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'ha5;
	endfunction

	function automatic line_t ref_line(input logic [15:0] base);
		line_t line;
		for (int b = 0; b < line_bytes; b++) begin
			line[8*b +: 8] = ref_mem[base + 16'(b)];
		end
		return line;
	endfunction

	function automatic string test_name(input logic [2:0] n);
		case (n)
			3'd1: return "idle after reset";
			3'd2: return "cold read";
			3'd3: return "repeated read hit";
			3'd4: return "masked write then read";
			3'd5: return "dirty eviction";
			3'd6: return "random mix";
			default: return "unnamed";
		endcase
	endfunction

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		test_errors++;
		errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		test_errors++;
		errors++;
	endtask

	task automatic close_test();
		if (test_num == 3'd2 && (fills != 1 || write_backs != 0)) begin
			report_failure("cold read did not cause exactly one fill and no write-back");
		end
		if (test_num == 3'd3 && (fills != 0 || write_backs != 0)) begin
			report_failure("read of a resident line went out to memory");
		end
		if (test_num == 3'd5 && write_backs == 0) begin
			report_failure("three lines in one set caused no write-back");
		end
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("test %0d %s: %s (%0d errors)", test_num, test_name(test_num),
			(test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
		fills = 0;
		write_backs = 0;
	endtask

	initial begin
		for (int a = 0; a < 65536; a++) begin
			ref_mem[a] = pattern_byte(16'(a));
		end
		errors = 0;
		test_errors = 0;
		fills = 0;
		write_backs = 0;
		tests_run = 0;
		tests_failed = 0;
		resp_seen = 1'b0;
		forever begin
			@(posedge clk);
			line_base = {mem_address.tag, mem_address.index, 4'h0};
			if (arst_n) begin
				if (pmem_read && pmem_write) begin
					report_failure("pmem_read and pmem_write both high");
				end
				if (!(mem_read || mem_write)) begin
					if (mem_resp) report_failure("mem_resp with no request pending");
					if (pmem_read || pmem_write) report_failure("memory strobe with no request");
					resp_seen = 1'b0;
				end
				if (pmem_resp && pmem_write) begin
					write_backs++;
					if (pmem_address[3:0] != 4'h0 || pmem_address[6:4] != mem_address.index ||
							pmem_address[15:7] == mem_address.tag) begin
						report_failure($sformatf("write-back address %h is not a victim",
							pmem_address));
					end else if (pmem_wdata != ref_line(pmem_address)) begin
						report_mismatch($sformatf("write-back to %h carries %h, expected %h",
							pmem_address, pmem_wdata, ref_line(pmem_address)));
					end
				end
				if (pmem_resp && pmem_read && pmem_address != line_base) begin
					report_mismatch($sformatf("fill from %h, expected %h", pmem_address,
						line_base));
				end
				if (pmem_resp && pmem_read) fills++;
				if (mem_resp && (mem_read || mem_write)) begin
					if (resp_seen) report_failure("second mem_resp for one request");
					resp_seen = 1'b1;
					if (mem_read && mem_rdata != ref_line(line_base)) begin
						report_mismatch($sformatf("read of %h returned %h, expected %h",
							line_base, mem_rdata, ref_line(line_base)));
					end
					if (mem_write) begin
						for (int b = 0; b < line_bytes; b++) begin
							if (mem_byte_enable[b]) begin
								ref_mem[line_base + 16'(b)] = mem_wdata[8*b +: 8];
							end
						end
					end
				end
				if (test_end) close_test();
				if (run_done) begin
					$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
						errors);
				end
			end
		end
	end

endmodule

//--- tb/l1_cache_tb.sv
`timescale 1ns/1ps

module l1_cache_tb;

	import cache_types_pkg::*;

	localparam int clk_period = 4;
	localparam int max_latency = 6;
	localparam int random_ops = 400;
	localparam int directed_ops = 10;
	localparam int op_cycles = 2 * max_latency + 8; // Write-back, fill, compare and idle.
	localparam int watchdog_ns = (random_ops + directed_ops + 20) * op_cycles * clk_period;

	logic clk;
	logic arst_n;
	logic mem_read;
	logic mem_write;
	cache_addr_t mem_address;
	line_t mem_wdata;
	byte_mask_t mem_byte_enable;
	logic mem_resp;
	line_t mem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic [15:0] pmem_address;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic pmem_resp;
	logic [2:0] test_num;
	logic test_end;
	logic run_done;
	int errors;
	int mem_latency;
	int mem_wait;
	logic [31:0] rand_state;
	line_t pmem_lines [4096];

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rand_state = xorshift(rand_state);
		return rand_state;
	endfunction

	// Every byte depends on all address bits.
	function automatic logic [7:0] pattern_byte(input logic [15:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'ha5;
	endfunction

	function automatic tag_t pool_tag(input logic [1:0] sel);
		case (sel)
			2'd0: return 9'h003;
			2'd1: return 9'h07c;
			2'd2: return 9'h112;
			default: return 9'h1e9;
		endcase
	endfunction

	function automatic cache_addr_t line_addr(input tag_t tag, input index_t index);
		return {tag, index, 4'h0};
	endfunction

	l1_cache i_l1_cache (
		.clk(clk),
		.arst_n(arst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.mem_resp(mem_resp),
		.mem_rdata(mem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	l1_cache_checker i_checker (
		.clk(clk),
		.arst_n(arst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.mem_resp(mem_resp),
		.mem_rdata(mem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_resp(pmem_resp),
		.test_num(test_num),
		.test_end(test_end),
		.run_done(run_done),
		.errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Physical memory answers after mem_latency falling edges.
	initial begin
		for (int l = 0; l < 4096; l++) begin
			for (int b = 0; b < 16; b++) begin
				pmem_lines[l][8*b +: 8] = pattern_byte(16'(l * 16 + b));
			end
		end
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		mem_wait = 0;
		forever begin
			@(negedge clk);
			if (pmem_resp) begin
				pmem_resp = 1'b0;
			end else if (pmem_read || pmem_write) begin
				mem_wait = mem_wait + 1;
				if (mem_wait >= mem_latency) begin
					mem_wait = 0;
					pmem_resp = 1'b1;
					if (pmem_read) begin
						pmem_rdata = pmem_lines[pmem_address[15:4]];
					end else begin
						pmem_lines[pmem_address[15:4]] = pmem_wdata;
					end
				end
			end
		end
	end

	// Starts and ends on a falling edge.
	task automatic do_access(input logic is_write, input cache_addr_t addr, input line_t data,
			input byte_mask_t mask);
		mem_latency = 1 + int'(next_rand() % max_latency);
		mem_read = !is_write;
		mem_write = is_write;
		mem_address = addr;
		mem_wdata = data;
		mem_byte_enable = mask;
		@(posedge clk);
		while (!mem_resp) @(posedge clk);
		@(negedge clk);
		mem_read = 1'b0;
		mem_write = 1'b0;
		@(negedge clk);
	endtask

	task automatic finish_test();
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin
		cache_addr_t addr;
		logic [31:0] r;
		logic [31:0] m;
		rand_state = 32'd98;
		mem_latency = 1;
		arst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		test_num = 3'd0;
		test_end = 1'b0;
		run_done = 1'b0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		test_num = 3'd1;
		repeat (8) @(negedge clk);
		finish_test();

		test_num = 3'd2;
		do_access(1'b0, line_addr(9'h0c4, 3'd5), '0, '0);
		finish_test();

		test_num = 3'd3;
		repeat (3) do_access(1'b0, line_addr(9'h0c4, 3'd5), '0, '0);
		finish_test();

		test_num = 3'd4;
		do_access(1'b1, line_addr(9'h0c4, 3'd5), {next_rand(), next_rand(), next_rand(),
			next_rand()}, 16'h0f35);
		do_access(1'b0, line_addr(9'h0c4, 3'd5), '0, '0);
		finish_test();

		// Three tags in set 2 evict the dirty LRU way.
		test_num = 3'd5;
		do_access(1'b1, line_addr(9'h011, 3'd2), {4{next_rand()}}, 16'h00ff);
		do_access(1'b1, line_addr(9'h0a3, 3'd2), {4{next_rand()}}, 16'hf0f0);
		do_access(1'b0, line_addr(9'h155, 3'd2), '0, '0);
		do_access(1'b0, line_addr(9'h011, 3'd2), '0, '0);
		finish_test();

		test_num = 3'd6;
		for (int n = 0; n < random_ops; n++) begin
			r = next_rand();
			m = next_rand();
			addr.tag = pool_tag(r[1:0]);
			addr.index = {1'b0, r[3:2]}; // Only four sets for more conflicts.
			addr.offset = r[7:4];
			do_access(r[8], addr, {next_rand(), next_rand(), next_rand(), next_rand()},
				m[15:0]);
		end
		finish_test();

		run_done = 1'b1;
		@(negedge clk);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#watchdog_ns;
		$display("Watchdog expired: a request never got mem_resp within the time limit");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- build.f
source/cache_types_pkg.sv
source/cache_array.sv
source/l1_cache_datapath.sv
source/l1_cache_control.sv
source/l1_cache.sv
tb/l1_cache_checker.sv
tb/l1_cache_tb.sv

//--- Makefile
SIM      := verilator
TOP      := l1_cache_tb
FILELIST := build.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
